// ==== dv/gmii_capture_tests.svh ====
task automatic test_reset();
  bus_word_t got;
  cur_test = "test_reset";
  for (int p = 0; p < NUM_PORTS; p++) begin
    bus_read(slot_addr(p, SREG_CTRL), got);
    check_equal($sformatf("slot %0d control", p), 0, got);
  end
  bus_read(glb_addr(GREG_IRQ), got);
  check_equal("irq register", 0, got);
  check_equal("irq_o", 0, irq_o);
endtask

task automatic test_counter_lanes();
  bus_word_t   hi_before;
  bus_word_t   lo_val;
  bus_word_t   got;
  logic [31:0] r;
  cur_test = "test_counter_lanes";
  bus_read(glb_addr(GREG_CNT_HI), hi_before);
  rand_bits(8, r);
  // Low lane data differs so a wrong lane write shows up
  bus_write(glb_addr(GREG_CNT_HI), {r[7:0], ~hi_before[7:0]}, 2'b10);
  bus_read(glb_addr(GREG_CNT_HI), got);
  check_equal("counter high after upper lane write", {r[7:0], hi_before[7:0]}, got);
  rand_bits(15, r);
  lo_val = r[15:0];
  bus_write(glb_addr(GREG_CNT_LO), lo_val, 2'b11);
  bus_read(glb_addr(GREG_CNT_LO), got);
  check_equal("counter low within 20 of written value", 1,
              (got >= lo_val) && (got <= lo_val + 20));
endtask

task automatic test_capture_one();
  bus_word_t got;
  bus_word_t cnt_before;
  bus_word_t cnt_after;
  int        len;
  cur_test = "test_capture_one";
  // Counter restarts near zero so its high half stays zero for this frame
  bus_write(glb_addr(GREG_CNT_LO), 16'h0000, 2'b11);
  bus_write(glb_addr(GREG_CNT_HI), 16'h0000, 2'b11);
  random_len(len);
  make_frame(0, len);
  bus_write(slot_addr(0, SREG_CTRL), 16'h0001, 2'b01);
  bus_read(glb_addr(GREG_CNT_LO), cnt_before);
  send_frame(0);
  wait_for_irq();
  bus_read(glb_addr(GREG_CNT_LO), cnt_after);
  bus_read(slot_addr(0, SREG_CTRL), got);
  check_equal("control done with armed clear", 16'h0002, got);
  bus_read(slot_addr(0, SREG_LEN), got);
  check_equal("frame length", len, got);
  bus_read(slot_addr(0, SREG_TS_HI), got);
  check_equal("timestamp high", 0, got);
  bus_read(slot_addr(0, SREG_TS_LO), got);
  check_equal("timestamp between counter reads", 1,
              (got >= cnt_before) && (got <= cnt_after));
  check_buffer(0);
endtask

task automatic test_arm_rules();
  bus_word_t got;
  int        len;
  cur_test = "test_arm_rules";
  random_len(len);
  make_frame(1, len);
  send_frame(1);
  bus_read(slot_addr(1, SREG_CTRL), got);
  check_equal("unarmed slot stays idle", 0, got);

  // Arm a few bytes into the frame
  random_len(len);
  make_frame(1, len);
  fork
    send_frame(1);
    begin
      repeat (4) @(posedge clk_125);
      bus_write(slot_addr(1, SREG_CTRL), 16'h0001, 2'b01);
    end
  join
  bus_read(slot_addr(1, SREG_CTRL), got);
  check_equal("frame in progress not captured", 16'h0001, got);

  random_len(len);
  make_frame(1, len);
  send_frame(1);
  bus_read(slot_addr(1, SREG_CTRL), got);
  check_equal("next frame captured", 16'h0002, got);
  bus_read(slot_addr(1, SREG_LEN), got);
  check_equal("next frame length", len, got);
  check_buffer(1);
endtask

task automatic test_two_slots();
  bus_word_t got;
  int        len;
  cur_test = "test_two_slots";
  for (int p = 0; p < NUM_PORTS; p++) begin
    random_len(len);
    make_frame(p, len);
    bus_write(slot_addr(p, SREG_CTRL), 16'h0001, 2'b01);
  end
  check_equal("irq_o low after arming", 0, irq_o);
  fork
    send_frame(0);
    send_frame(1);
  join
  bus_read(glb_addr(GREG_IRQ), got);
  check_equal("both done bits", 16'h0003, got);
  for (int p = 0; p < NUM_PORTS; p++) begin
    bus_read(slot_addr(p, SREG_LEN), got);
    check_equal($sformatf("slot %0d length", p), frame_len[p], got);
    check_buffer(p);
  end
  bus_write(slot_addr(0, SREG_CTRL), 16'h0001, 2'b01);
  bus_read(glb_addr(GREG_IRQ), got);
  check_equal("done bits after slot 0 re-arm", 16'h0002, got);
  check_equal("irq_o held by slot 1", 1, irq_o);
  bus_write(slot_addr(1, SREG_CTRL), 16'h0001, 2'b01);
  bus_read(glb_addr(GREG_IRQ), got);
  check_equal("done bits after slot 1 re-arm", 0, got);
  check_equal("irq_o after last re-arm", 0, irq_o);
endtask

task automatic test_unmapped();
  bus_word_t got;
  int        regions [5] = '{1, 2, 3, 6, 7};
  cur_test = "test_unmapped";
  foreach (regions[i]) begin
    bus_write(reg_addr(regions[i], 5), 16'hffff, 2'b11);
    bus_read(reg_addr(regions[i], 5), got);
    check_equal($sformatf("region %0d reads zero", regions[i]), 0, got);
  end
  bus_write(glb_addr(3), 16'hffff, 2'b11);
  bus_read(glb_addr(3), got);
  check_equal("unused global offset reads zero", 0, got);
  bus_read(glb_addr(12'hfff), got);
  check_equal("top global offset reads zero", 0, got);
endtask

// ==== dv/gmii_capture_tb.sv ====
`timescale 1ns/10ps

module gmii_capture_tb
  import bus_pkg::*, frame_pkg::*;
();

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 10;
  localparam int DRIVE_DELAY   = 1;
  localparam int NUM_TESTS     = 6;
  localparam int MAX_FRAME_LEN = 200;
  localparam int ACK_LIMIT     = 16;
  localparam int IDLE_CYCLES   = 12;

  logic                  clk_125 = 1'b0;
  logic                  core_rst_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [BUS_ADDR_W-1:0] wb_adr;
  logic [1:0]            wb_sel;
  bus_word_t             wb_dat_in;
  bus_word_t             wb_dat_o;
  logic                  wb_ack_o;
  logic [NUM_PORTS-1:0]  gmii_rx_dv;
  gmii_byte_t            gmii_rxd [NUM_PORTS];
  logic                  irq_o;

  string                 cur_test = "";
  logic [31:0]           lfsr_state = 32'hd0f8eb2e;
  gmii_byte_t            frame_mem [NUM_PORTS][MAX_FRAME_LEN];
  int                    frame_len [NUM_PORTS];

  always #(CLK_PERIOD / 2) clk_125 = ~clk_125;

  gmii_capture_top DUT (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_sel_i     (wb_sel),
    .wb_dat_i     (wb_dat_in),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .gmii_rx_dv_i (gmii_rx_dv),
    .gmii_rxd_i   (gmii_rxd),
    .irq_o        (irq_o)
  );

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic check_equal(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %h actual %h", cur_test, what, exp, act);
      abort_run();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  task automatic random_len(output int len);
    logic [31:0] v;
    rand_bits(8, v);
    len = 16 + int'(v % 185);
  endtask

  task automatic make_frame(input int port, input int len);
    logic [31:0] v;
    frame_len[port] = len;
    for (int i = 0; i < len; i++) begin
      rand_bits(8, v);
      frame_mem[port][i] = v[7:0];
    end
  endtask

  function automatic logic [BUS_ADDR_W-1:0] reg_addr(input int region, input int offset);
    logic [BUS_ADDR_W-1:0] a;
    a = '0;
    a[REGION_MSB:REGION_LSB] = region[REGION_MSB-REGION_LSB:0];
    a[REGION_LSB-1:1]        = offset[REG_OFFSET_W-1:0];
    return a;
  endfunction

  function automatic logic [BUS_ADDR_W-1:0] glb_addr(input int offset);
    return reg_addr(int'(REGION_GLOBAL), offset);
  endfunction

  function automatic logic [BUS_ADDR_W-1:0] slot_addr(input int port, input int offset);
    return reg_addr(int'(REGION_SLOT_BASE) + port, offset);
  endfunction

  // ------------------------------
  // Bus and GMII drivers
  // ------------------------------
  task automatic bus_access(input logic we, input logic [BUS_ADDR_W-1:0] addr,
                            input logic [1:0] sel, input bus_word_t wdata,
                            output bus_word_t rdata);
    int waited = 0;
    @(posedge clk_125);
    #DRIVE_DELAY;
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = we;
    wb_adr    = addr;
    wb_sel    = sel;
    wb_dat_in = wdata;
    do begin
      @(posedge clk_125);
      #DRIVE_DELAY;
      waited++;
      if (waited > ACK_LIMIT) begin
        $display("Bus access to address %h was never acknowledged", addr);
        abort_run();
      end
    end while (!wb_ack_o);
    rdata  = wb_dat_o;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input bus_word_t data,
                           input logic [1:0] sel);
    bus_word_t unused;
    bus_access(1'b1, addr, sel, data, unused);
  endtask

  task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output bus_word_t data);
    bus_access(1'b0, addr, 2'b11, 16'h0000, data);
  endtask

  task automatic send_frame(input int port);
    for (int i = 0; i < frame_len[port]; i++) begin
      @(posedge clk_125);
      #DRIVE_DELAY;
      gmii_rx_dv[port] = 1'b1;
      gmii_rxd[port]   = frame_mem[port][i];
    end
    @(posedge clk_125);
    #DRIVE_DELAY;
    gmii_rx_dv[port] = 1'b0;
    gmii_rxd[port]   = '0;
    repeat (IDLE_CYCLES) @(posedge clk_125);
    #DRIVE_DELAY;
  endtask

  task automatic wait_for_irq();
    int waited = 0;
    while (!irq_o) begin
      @(posedge clk_125);
      #DRIVE_DELAY;
      waited++;
      if (waited > 4 * MAX_FRAME_LEN) begin
        $display("Interrupt never rose after the frame ended");
        abort_run();
      end
    end
  endtask

  // Odd frames leave the high lane of the last word outside the frame
  task automatic check_buffer(input int port);
    bus_word_t got;
    bus_word_t exp;
    for (int k = 0; k < (frame_len[port] + 1) / 2; k++) begin
      bus_read(slot_addr(port, FRAME_BASE_WORD + k), got);
      exp = {8'h00, frame_mem[port][2*k]};
      if (2*k + 1 < frame_len[port]) begin
        exp[15:8] = frame_mem[port][2*k+1];
      end else begin
        got[15:8] = 8'h00;
      end
      check_equal($sformatf("slot %0d buffer word %0d", port, k), exp, got);
    end
  endtask

  `include "gmii_capture_tests.svh"

  // ------------------------------
  // Sequence
  // ------------------------------
  initial begin
    core_rst_n = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_sel     = '0;
    wb_dat_in  = '0;
    gmii_rx_dv = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      gmii_rxd[p] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_125);
    #DRIVE_DELAY;
    core_rst_n = 1'b1;

    test_reset();
    test_counter_lanes();
    test_capture_one();
    test_arm_rules();
    test_two_slots();
    test_unmapped();

    $display("all tests passed");
    $finish;
  end

  initial begin
    #(NUM_TESTS * 4 * MAX_FRAME_LEN * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    abort_run();
  end

endmodule

// ==== gmii_capture.f ====
+incdir+dv
src/bus_pkg.sv
src/frame_pkg.sv
src/frame_buffer_ram.sv
src/wb_target_decode.sv
src/rx_frame_slot.sv
src/wb_read_mux.sv
src/gmii_capture_top.sv
dv/gmii_capture_tb.sv

// ==== src/bus_pkg.sv ====
package bus_pkg;

  // ------------------------------
  // Host bus
  // ------------------------------
  typedef logic [15:0] bus_word_t;

  localparam int BUS_ADDR_W = 16;

  // Region field of the byte address
  localparam int REGION_MSB = 15;
  localparam int REGION_LSB = 13;

  localparam logic [REGION_MSB-REGION_LSB:0] REGION_GLOBAL    = 3'd0;
  localparam logic [REGION_MSB-REGION_LSB:0] REGION_SLOT_BASE = 3'd4;

  // Word offset inside a region, byte address bits 12:1
  localparam int REG_OFFSET_W = 12;

  // ------------------------------
  // Register offsets
  // ------------------------------
  localparam logic [REG_OFFSET_W-1:0] GREG_IRQ    = 12'd0;
  localparam logic [REG_OFFSET_W-1:0] GREG_CNT_LO = 12'd1;
  localparam logic [REG_OFFSET_W-1:0] GREG_CNT_HI = 12'd2;

  localparam logic [REG_OFFSET_W-1:0] SREG_TS_LO = 12'd0;
  localparam logic [REG_OFFSET_W-1:0] SREG_TS_HI = 12'd1;
  localparam logic [REG_OFFSET_W-1:0] SREG_LEN   = 12'd2;
  localparam logic [REG_OFFSET_W-1:0] SREG_CTRL  = 12'd3;

  // Offsets from here up hit the frame buffer
  localparam int SLOT_REG_WORDS = 4;

endpackage

// ==== src/frame_buffer_ram.sv ====
`timescale 1ns/10ps

module frame_buffer_ram
  import bus_pkg::*, frame_pkg::*;
(
  input  logic                  clk_125,
  input  logic                  wr_en_i,
  input  logic [BUF_ADDR_W-1:0] wr_addr_i,
  input  logic [1:0]            wr_be_i,
  input  bus_word_t             wr_data_i,
  input  logic [BUF_ADDR_W-1:0] rd_addr_i,
  output bus_word_t             rd_data_o
);

  bus_word_t mem [BUF_WORDS];

  // Byte-lane write, lane 0 is bits 7:0
  always_ff @(posedge clk_125) begin
    if (wr_en_i) begin
      for (int b = 0; b < 2; b++) begin
        if (wr_be_i[b]) begin
          mem[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  // Registered read, one cycle
  always_ff @(posedge clk_125) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// ==== src/frame_pkg.sv ====
package frame_pkg;

  // ------------------------------
  // Receive ports
  // ------------------------------
  localparam int NUM_PORTS = 2;

  typedef logic [7:0] gmii_byte_t;

  localparam int FRAME_LEN_W = 12;

  typedef logic [FRAME_LEN_W-1:0] frame_len_t;
  typedef logic [31:0]            timestamp_t;

  // ------------------------------
  // Frame buffer
  // ------------------------------
  localparam int BUF_ADDR_W = 12;
  localparam int BUF_WORDS  = 4096;

  // Byte 0 of a frame sits in this word, right after the slot registers
  localparam int FRAME_BASE_WORD = 4;

  // Slot control word
  localparam int CTRL_ARM_BIT  = 0;
  localparam int CTRL_DONE_BIT = 1;

endpackage

// ==== src/gmii_capture_top.sv ====
`timescale 1ns/10ps

module gmii_capture_top
  import bus_pkg::*, frame_pkg::*;
(
  input  logic                  clk_125,
  input  logic                  core_rst_n,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [BUS_ADDR_W-1:0] wb_adr_i,
  input  logic [1:0]            wb_sel_i,
  input  bus_word_t             wb_dat_i,
  output bus_word_t             wb_dat_o,
  output logic                  wb_ack_o,
  input  logic [NUM_PORTS-1:0]  gmii_rx_dv_i,
  input  gmii_byte_t            gmii_rxd_i [NUM_PORTS],
  output logic                  irq_o
);

  logic                    req_start;
  logic                    req_we;
  logic [REG_OFFSET_W-1:0] req_offset;
  logic [1:0]              req_sel;
  bus_word_t               req_data;
  logic [NUM_PORTS-1:0]    slot_sel;
  timestamp_t              global_count;
  logic                    glb_rsp_valid;
  bus_word_t               glb_rsp_data;
  logic [NUM_PORTS-1:0]    slot_rsp_valid;
  bus_word_t               slot_rsp_data [NUM_PORTS];
  logic [NUM_PORTS-1:0]    slot_done;

  wb_target_decode u_decode (
    .clk_125        (clk_125),
    .core_rst_n     (core_rst_n),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_sel_i       (wb_sel_i),
    .wb_dat_i       (wb_dat_i),
    .slot_done_i    (slot_done),
    .req_start_o    (req_start),
    .req_we_o       (req_we),
    .req_offset_o   (req_offset),
    .req_sel_o      (req_sel),
    .req_data_o     (req_data),
    .slot_sel_o     (slot_sel),
    .global_count_o (global_count),
    .rsp_valid_o    (glb_rsp_valid),
    .rsp_data_o     (glb_rsp_data),
    .irq_o          (irq_o)
  );

  // One capture slot per receive port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_slot
    rx_frame_slot u_slot (
      .clk_125        (clk_125),
      .core_rst_n     (core_rst_n),
      .req_start_i    (req_start),
      .req_we_i       (req_we),
      .req_offset_i   (req_offset),
      .req_sel_i      (req_sel),
      .req_data_i     (req_data),
      .slot_sel_i     (slot_sel[p]),
      .global_count_i (global_count),
      .gmii_rx_dv_i   (gmii_rx_dv_i[p]),
      .gmii_rxd_i     (gmii_rxd_i[p]),
      .rsp_valid_o    (slot_rsp_valid[p]),
      .rsp_data_o     (slot_rsp_data[p]),
      .done_o         (slot_done[p])
    );
  end

  wb_read_mux u_rd_mux (
    .clk_125        (clk_125),
    .core_rst_n     (core_rst_n),
    .global_valid_i (glb_rsp_valid),
    .global_data_i  (glb_rsp_data),
    .slot_valid_i   (slot_rsp_valid),
    .slot_data_i    (slot_rsp_data),
    .wb_ack_o       (wb_ack_o),
    .wb_dat_o       (wb_dat_o)
  );

endmodule

// ==== src/rx_frame_slot.sv ====
`timescale 1ns/10ps

module rx_frame_slot
  import bus_pkg::*, frame_pkg::*;
(
  input  logic                    clk_125,
  input  logic                    core_rst_n,
  input  logic                    req_start_i,
  input  logic                    req_we_i,
  input  logic [REG_OFFSET_W-1:0] req_offset_i,
  input  logic [1:0]              req_sel_i,
  input  bus_word_t               req_data_i,
  input  logic                    slot_sel_i,
  input  timestamp_t              global_count_i,
  input  logic                    gmii_rx_dv_i,
  input  gmii_byte_t              gmii_rxd_i,
  output logic                    rsp_valid_o,
  output bus_word_t               rsp_data_o,
  output logic                    done_o
);

  logic                  armed_q;
  logic                  done_q;
  logic                  capturing_q;
  logic                  seen_low_q;
  logic                  buf_pend_q;
  logic                  host_acc;
  logic                  reg_acc;
  logic                  arm_wr;
  logic                  cap_start;
  logic                  cap_wr;
  frame_len_t            byte_cnt_q;
  frame_len_t            byte_idx;
  frame_len_t            len_q;
  timestamp_t            ts_q;
  logic [BUF_ADDR_W-1:0] wr_addr;
  logic [1:0]            wr_be;
  bus_word_t             ram_rd_data;
  bus_word_t             reg_rd_data;

  assign host_acc = req_start_i && slot_sel_i;
  assign reg_acc  = req_offset_i < SLOT_REG_WORDS;
  assign arm_wr   = host_acc && req_we_i && (req_offset_i == SREG_CTRL) &&
                    req_sel_i[0] && req_data_i[CTRL_ARM_BIT];

  // ------------------------------
  // Capture
  // ------------------------------
  // Start only on a rising dv edge seen after arming
  assign cap_start = armed_q && seen_low_q && !capturing_q && gmii_rx_dv_i;
  assign cap_wr    = gmii_rx_dv_i && (capturing_q || cap_start);
  assign byte_idx  = capturing_q ? byte_cnt_q : '0;

  // Even bytes to the low lane, odd bytes to the high lane
  assign wr_addr = BUF_ADDR_W'(FRAME_BASE_WORD) + BUF_ADDR_W'(byte_idx >> 1);
  assign wr_be   = byte_idx[0] ? 2'b10 : 2'b01;

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      armed_q     <= 1'b0;
      done_q      <= 1'b0;
      capturing_q <= 1'b0;
      seen_low_q  <= 1'b0;
      byte_cnt_q  <= '0;
      len_q       <= '0;
      ts_q        <= '0;
    end else begin
      if (cap_start) begin
        capturing_q <= 1'b1;
        ts_q        <= global_count_i;
        byte_cnt_q  <= frame_len_t'(1);
      end else if (capturing_q) begin
        if (gmii_rx_dv_i) begin
          byte_cnt_q <= byte_cnt_q + 1'b1;
        end else begin
          capturing_q <= 1'b0;
          len_q       <= byte_cnt_q;
          done_q      <= 1'b1;
          armed_q     <= 1'b0;
        end
      end
      if (armed_q && !gmii_rx_dv_i) begin
        seen_low_q <= 1'b1;
      end
      // Host arm wins over everything above
      if (arm_wr) begin
        armed_q    <= 1'b1;
        done_q     <= 1'b0;
        seen_low_q <= 1'b0;
      end
    end
  end

  frame_buffer_ram u_buf (
    .clk_125   (clk_125),
    .wr_en_i   (cap_wr),
    .wr_addr_i (wr_addr),
    .wr_be_i   (wr_be),
    .wr_data_i ({gmii_rxd_i, gmii_rxd_i}),
    .rd_addr_i (BUF_ADDR_W'(req_offset_i)),
    .rd_data_o (ram_rd_data)
  );

  // ------------------------------
  // Host reads
  // ------------------------------
  always_comb begin
    reg_rd_data = '0;
    case (req_offset_i)
      SREG_TS_LO: reg_rd_data = ts_q[15:0];
      SREG_TS_HI: reg_rd_data = ts_q[31:16];
      SREG_LEN:   reg_rd_data[FRAME_LEN_W-1:0] = len_q;
      SREG_CTRL: begin
        reg_rd_data[CTRL_ARM_BIT]  = armed_q;
        reg_rd_data[CTRL_DONE_BIT] = done_q;
      end
      default:    reg_rd_data = '0;
    endcase
  end

  // Buffer accesses answer one cycle later than registers
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      rsp_valid_o <= 1'b0;
      buf_pend_q  <= 1'b0;
    end else begin
      rsp_valid_o <= (host_acc && reg_acc) || buf_pend_q;
      buf_pend_q  <= host_acc && !reg_acc;
    end
  end

  always_ff @(posedge clk_125) begin
    if (host_acc && reg_acc) begin
      rsp_data_o <= reg_rd_data;
    end else if (buf_pend_q) begin
      rsp_data_o <= ram_rd_data;
    end
  end

  assign done_o = done_q;

  a_done_excl_capture: assert property (
    @(posedge clk_125) disable iff (!core_rst_n) !(done_q && capturing_q));

  a_rsp_single_pulse: assert property (
    @(posedge clk_125) disable iff (!core_rst_n) rsp_valid_o |=> !rsp_valid_o);

endmodule

// ==== src/wb_read_mux.sv ====
`timescale 1ns/10ps

module wb_read_mux
  import bus_pkg::*, frame_pkg::*;
(
  input  logic                 clk_125,
  input  logic                 core_rst_n,
  input  logic                 global_valid_i,
  input  bus_word_t            global_data_i,
  input  logic [NUM_PORTS-1:0] slot_valid_i,
  input  bus_word_t            slot_data_i [NUM_PORTS],
  output logic                 wb_ack_o,
  output bus_word_t            wb_dat_o
);

  logic      any_valid;
  bus_word_t sel_data;

  assign any_valid = global_valid_i || (|slot_valid_i);

  // Only one source answers a given request
  always_comb begin
    sel_data = global_valid_i ? global_data_i : '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (slot_valid_i[p]) begin
        sel_data = slot_data_i[p];
      end
    end
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= any_valid;
    end
  end

  always_ff @(posedge clk_125) begin
    if (any_valid) begin
      wb_dat_o <= sel_data;
    end
  end

  a_one_responder: assert property (
    @(posedge clk_125) disable iff (!core_rst_n)
    $onehot0({global_valid_i, slot_valid_i}));

endmodule

// ==== src/wb_target_decode.sv ====
`timescale 1ns/10ps

module wb_target_decode
  import bus_pkg::*, frame_pkg::*;
(
  input  logic                    clk_125,
  input  logic                    core_rst_n,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [BUS_ADDR_W-1:0]   wb_adr_i,
  input  logic [1:0]              wb_sel_i,
  input  bus_word_t               wb_dat_i,
  input  logic [NUM_PORTS-1:0]    slot_done_i,
  output logic                    req_start_o,
  output logic                    req_we_o,
  output logic [REG_OFFSET_W-1:0] req_offset_o,
  output logic [1:0]              req_sel_o,
  output bus_word_t               req_data_o,
  output logic [NUM_PORTS-1:0]    slot_sel_o,
  output timestamp_t              global_count_o,
  output logic                    rsp_valid_o,
  output bus_word_t               rsp_data_o,
  output logic                    irq_o
);

  logic [REGION_MSB-REGION_LSB:0] region;
  logic [NUM_PORTS-1:0]           slot_hit;
  logic                           new_req;
  logic                           req_seen_q;
  logic                           glb_q;
  logic                           glb_wr;
  timestamp_t                     count_d;
  bus_word_t                      glb_rd_data;

  assign region  = wb_adr_i[REGION_MSB:REGION_LSB];
  assign new_req = wb_cyc_i && wb_stb_i && !req_seen_q;

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      slot_hit[p] = (int'(region) == int'(REGION_SLOT_BASE) + p);
    end
  end

  // ------------------------------
  // Request detect
  // ------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      req_start_o <= 1'b0;
      req_seen_q  <= 1'b0;
    end else begin
      req_start_o <= new_req;
      if (!wb_stb_i) begin
        req_seen_q <= 1'b0;
      end else if (wb_cyc_i) begin
        req_seen_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_125) begin
    if (new_req) begin
      req_we_o     <= wb_we_i;
      req_offset_o <= wb_adr_i[REGION_LSB-1:1];
      req_sel_o    <= wb_sel_i;
      req_data_o   <= wb_dat_i;
      slot_sel_o   <= slot_hit;
      glb_q        <= (region == REGION_GLOBAL);
    end
  end

  // ------------------------------
  // Global counter
  // ------------------------------
  assign glb_wr = req_start_o && req_we_o && glb_q;

  always_comb begin
    count_d = global_count_o + 1'b1;
    if (glb_wr && (req_offset_o == GREG_CNT_LO || req_offset_o == GREG_CNT_HI)) begin
      count_d = global_count_o;
      for (int b = 0; b < 2; b++) begin
        if (req_sel_o[b]) begin
          if (req_offset_o == GREG_CNT_LO) begin
            count_d[8*b +: 8] = req_data_o[8*b +: 8];
          end else begin
            count_d[16 + 8*b +: 8] = req_data_o[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      global_count_o <= '0;
    end else begin
      global_count_o <= count_d;
    end
  end

  // Unmapped regions fall through to zero
  always_comb begin
    glb_rd_data = '0;
    if (glb_q) begin
      case (req_offset_o)
        GREG_IRQ:    glb_rd_data[NUM_PORTS-1:0] = slot_done_i;
        GREG_CNT_LO: glb_rd_data = global_count_o[15:0];
        GREG_CNT_HI: glb_rd_data = global_count_o[31:16];
        default:     glb_rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_start_o && !(|slot_sel_o);
    end
  end

  always_ff @(posedge clk_125) begin
    if (req_start_o) begin
      rsp_data_o <= glb_rd_data;
    end
  end

  assign irq_o = |slot_done_i;

endmodule
